/* Bender.yml */
package:
  name: kvs_bench

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/kvs_bench_pkg.sv
      - verilog/ctrl_regs.sv
      - verilog/experiment_timer.sv
      - verilog/dram_addr_slice.sv
      - verilog/kvs_bench_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/kvs_bench_tb.sv

/* dv/kvs_bench_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kvs_bench_params.svh"

module kvs_bench_tb;

  localparam int AXI_TIMEOUT = 64;
  localparam int RUN_POLL_LIMIT = 400;
  localparam int ZERO_RUN_POLLS = 4;
  localparam int STREAM_TIMEOUT = 20000;
  localparam int REQS_PER_STREAM = 300;

  logic ap_clk = 1'b0;
  logic ap_rst_n;

  // control bus
  logic awvalid;
  logic wvalid;
  logic bready;
  logic arvalid;
  logic rready;
  logic [3:0] wstrb;
  kvs_bench_pkg::axil_addr_t awaddr;
  kvs_bench_pkg::axil_addr_t araddr;
  kvs_bench_pkg::axil_data_t wdata;
  wire awready;
  wire wready;
  wire bvalid;
  wire arready;
  wire rvalid;
  wire [1:0] bresp;
  wire [1:0] rresp;
  wire [`KVS_AXIL_DATA_W-1:0] rdata;

  // streams 0..3 are c0 aw, c0 ar, c1 aw, c1 ar
  logic [3:0] req_valid;
  logic [3:0] gl_ready;
  kvs_bench_pkg::local_addr_t [3:0] req_addr;
  wire [3:0] req_ready;
  wire [3:0] gl_valid;
  wire [3:0][`KVS_MEM_ADDR_W-1:0] gl_addr;

  kvs_bench_pkg::mem_addr_t q_c0_aw[$];
  kvs_bench_pkg::mem_addr_t q_c0_ar[$];
  kvs_bench_pkg::mem_addr_t q_c1_aw[$];
  kvs_bench_pkg::mem_addr_t q_c1_ar[$];
  int checked [4];
  string test_name;
  kvs_bench_pkg::mem_addr_t ptr0_val;
  kvs_bench_pkg::mem_addr_t ptr1_val;

  always #5 ap_clk = ~ap_clk;

  kvs_bench_top kvs_bench_top_inst (
    .ap_clk                (ap_clk),
    .ap_rst_n              (ap_rst_n),
    .s_axi_control_awvalid (awvalid),
    .s_axi_control_awready (awready),
    .s_axi_control_awaddr  (awaddr),
    .s_axi_control_wvalid  (wvalid),
    .s_axi_control_wready  (wready),
    .s_axi_control_wdata   (wdata),
    .s_axi_control_wstrb   (wstrb),
    .s_axi_control_arvalid (arvalid),
    .s_axi_control_arready (arready),
    .s_axi_control_araddr  (araddr),
    .s_axi_control_rvalid  (rvalid),
    .s_axi_control_rready  (rready),
    .s_axi_control_rdata   (rdata),
    .s_axi_control_rresp   (rresp),
    .s_axi_control_bvalid  (bvalid),
    .s_axi_control_bready  (bready),
    .s_axi_control_bresp   (bresp),
    .c0_awaddr_local       (req_addr[0]),
    .c0_awvalid_local      (req_valid[0]),
    .c0_awready_local      (req_ready[0]),
    .c0_araddr_local       (req_addr[1]),
    .c0_arvalid_local      (req_valid[1]),
    .c0_arready_local      (req_ready[1]),
    .c1_awaddr_local       (req_addr[2]),
    .c1_awvalid_local      (req_valid[2]),
    .c1_awready_local      (req_ready[2]),
    .c1_araddr_local       (req_addr[3]),
    .c1_arvalid_local      (req_valid[3]),
    .c1_arready_local      (req_ready[3]),
    .c0_s_axi_awaddr       (gl_addr[0]),
    .c0_s_axi_awvalid      (gl_valid[0]),
    .c0_s_axi_awready      (gl_ready[0]),
    .c0_s_axi_araddr       (gl_addr[1]),
    .c0_s_axi_arvalid      (gl_valid[1]),
    .c0_s_axi_arready      (gl_ready[1]),
    .c1_s_axi_awaddr       (gl_addr[2]),
    .c1_s_axi_awvalid      (gl_valid[2]),
    .c1_s_axi_awready      (gl_ready[2]),
    .c1_s_axi_araddr       (gl_addr[3]),
    .c1_s_axi_arvalid      (gl_valid[3]),
    .c1_s_axi_arready      (gl_ready[3])
  );

  ////////////////////////////////////////////////////////////
  // reference model and reporting
  ////////////////////////////////////////////////////////////
  // base plus zero-extended local offset wraps at 64 bits
  function automatic kvs_bench_pkg::mem_addr_t expected_global(
    input kvs_bench_pkg::mem_addr_t base,
    input kvs_bench_pkg::local_addr_t local_addr
  );
    kvs_bench_pkg::mem_addr_t widened;
    widened = {{(`KVS_MEM_ADDR_W-`KVS_LOCAL_ADDR_W){1'b0}}, local_addr};
    return base + widened;
  endfunction

  function automatic kvs_bench_pkg::mem_addr_t base_for_stream(input int s);
    return (s < 2) ? ptr0_val : ptr1_val; // c0 streams first
  endfunction

  function automatic kvs_bench_pkg::axil_data_t ctrl_word(
    input logic start, input logic done, input logic idle, input logic ready
  );
    kvs_bench_pkg::axil_data_t w;
    w = '0;
    w[`KVS_BIT_START] = start;
    w[`KVS_BIT_DONE] = done;
    w[`KVS_BIT_IDLE] = idle;
    w[`KVS_BIT_READY] = ready;
    return w;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] want,
                             input logic [63:0] got);
    assert (got === want) else begin
      $display("mismatch %s expected %h actual %h", name, want, got);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic push_expected(input int s, input kvs_bench_pkg::mem_addr_t a);
    case (s)
      0: q_c0_aw.push_back(a);
      1: q_c0_ar.push_back(a);
      2: q_c1_aw.push_back(a);
      default: q_c1_ar.push_back(a);
    endcase
  endtask

  task automatic pop_expected(input int s, output kvs_bench_pkg::mem_addr_t a,
                              output bit found);
    a = '0;
    case (s)
      0: found = (q_c0_aw.size() > 0);
      1: found = (q_c0_ar.size() > 0);
      2: found = (q_c1_aw.size() > 0);
      default: found = (q_c1_ar.size() > 0);
    endcase
    if (found) begin
      case (s)
        0: a = q_c0_aw.pop_front();
        1: a = q_c0_ar.pop_front();
        2: a = q_c1_aw.pop_front();
        default: a = q_c1_ar.pop_front();
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI-Lite host tasks start right after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic axil_write(input kvs_bench_pkg::axil_addr_t addr,
                            input kvs_bench_pkg::axil_data_t data);
    int t;
    awvalid <= 1'b1;
    awaddr <= addr;
    wvalid <= 1'b1;
    wdata <= data;
    wstrb <= 4'hF;
    t = 0;
    do begin
      @(posedge ap_clk);
      t++;
      assert (t <= AXI_TIMEOUT) else fail_now("write address and data were never accepted");
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    t = 0;
    do begin
      @(posedge ap_clk);
      t++;
      assert (t <= AXI_TIMEOUT) else fail_now("write response never arrived");
    end while (!bvalid); // bready stays high
    check_value("bresp", 2'b00, bresp);
  endtask

  task automatic axil_read(input kvs_bench_pkg::axil_addr_t addr,
                           output kvs_bench_pkg::axil_data_t data);
    int t;
    arvalid <= 1'b1;
    araddr <= addr;
    t = 0;
    do begin
      @(posedge ap_clk);
      t++;
      assert (t <= AXI_TIMEOUT) else fail_now("read address was never accepted");
    end while (!arready);
    arvalid <= 1'b0;
    t = 0;
    do begin
      @(posedge ap_clk);
      t++;
      assert (t <= AXI_TIMEOUT) else fail_now("read data never arrived");
    end while (!rvalid);
    data = rdata;
    check_value("rresp", 2'b00, rresp);
  endtask

  task automatic write_reg64(input kvs_bench_pkg::axil_addr_t lo_addr,
                             input logic [63:0] value);
    axil_write(lo_addr, value[31:0]);
    axil_write(lo_addr + 12'h4, value[63:32]);
  endtask

  task automatic check_reg64(input string name, input kvs_bench_pkg::axil_addr_t lo_addr,
                             input logic [63:0] value);
    kvs_bench_pkg::axil_data_t rd;
    axil_read(lo_addr, rd);
    check_value({name, " lo"}, value[31:0], rd);
    axil_read(lo_addr + 12'h4, rd);
    check_value({name, " hi"}, value[63:32], rd);
  endtask

  ////////////////////////////////////////////////////////////
  // address streams
  ////////////////////////////////////////////////////////////
  task automatic run_traffic(input string name, input int n, input bit stall);
    int sent [4];
    int cycles;
    bit all_done;
    test_name = name;
    for (int i = 0; i < 4; i++) begin
      sent[i] = 0;
      checked[i] = 0;
    end
    cycles = 0;
    all_done = 1'b0;
    while (!all_done) begin
      @(posedge ap_clk);
      cycles++;
      assert (cycles <= STREAM_TIMEOUT) else fail_now("address streams did not drain in time");
      all_done = 1'b1;
      for (int i = 0; i < 4; i++) begin
        if (req_valid[i] && req_ready[i]) begin
          push_expected(i, expected_global(base_for_stream(i), req_addr[i]));
          sent[i]++;
        end
        // a held request keeps its address until taken
        if (!req_valid[i] || req_ready[i]) begin
          if (sent[i] < n && $urandom_range(3) != 0) begin
            req_valid[i] <= 1'b1;
            req_addr[i] <= kvs_bench_pkg::local_addr_t'({$urandom, $urandom});
          end else begin
            req_valid[i] <= 1'b0;
          end
        end
        gl_ready[i] <= stall ? ($urandom_range(1) == 1) : 1'b1;
        if (checked[i] < n) all_done = 1'b0;
      end
    end
    gl_ready <= '1;
  endtask

  // handshakes for the next rising edge are settled here
  always @(negedge ap_clk) begin
    kvs_bench_pkg::mem_addr_t want;
    bit found;
    if (ap_rst_n) begin
      for (int i = 0; i < 4; i++) begin
        if (gl_valid[i] && gl_ready[i]) begin
          pop_expected(i, want, found);
          assert (found) else fail_now($sformatf("stream %0d sent an extra request", i));
          check_value($sformatf("%s stream %0d", test_name, i), want, gl_addr[i]);
          checked[i]++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    kvs_bench_pkg::axil_data_t rd;
    logic [63:0] cycles_val;
    int run_len;
    int polls;
    void'($urandom(32'hddffe52e));
    ap_rst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;
    req_valid = '0;
    req_addr = '0;
    gl_ready = '1;
    test_name = "idle";
    repeat (2) @(posedge ap_clk);
    ap_rst_n <= 1'b1;
    @(posedge ap_clk);

    axil_read(`KVS_REG_AP_CTRL, rd);
    check_value("reset ap_ctrl", ctrl_word(0, 0, 1, 0), rd);

    cycles_val = {$urandom, $urandom};
    ptr0_val = {$urandom, $urandom};
    ptr1_val = {$urandom, $urandom};
    write_reg64(`KVS_REG_CYCLES_LO, cycles_val);
    write_reg64(`KVS_REG_PTR0_LO, ptr0_val);
    write_reg64(`KVS_REG_PTR1_LO, ptr1_val);
    check_reg64("readback cycles", `KVS_REG_CYCLES_LO, cycles_val);
    check_reg64("readback ptr0", `KVS_REG_PTR0_LO, ptr0_val);
    check_reg64("readback ptr1", `KVS_REG_PTR1_LO, ptr1_val);

    // timed run long enough that the first poll sees it busy
    run_len = 20 + $urandom_range(179);
    write_reg64(`KVS_REG_CYCLES_LO, 64'(run_len));
    axil_write(`KVS_REG_AP_CTRL, ctrl_word(1, 0, 0, 0));
    axil_read(`KVS_REG_AP_CTRL, rd);
    check_value("run busy", ctrl_word(1, 0, 0, 0), rd);
    polls = 0;
    while (!rd[`KVS_BIT_IDLE]) begin
      polls++;
      assert (polls <= RUN_POLL_LIMIT) else fail_now("experiment run never went idle");
      check_value("run busy", ctrl_word(1, 0, 0, 0), rd);
      axil_read(`KVS_REG_AP_CTRL, rd);
    end
    check_value("run done", ctrl_word(0, 1, 1, 1), rd);
    axil_read(`KVS_REG_AP_CTRL, rd);
    check_value("run done cleared", ctrl_word(0, 0, 1, 0), rd);

    write_reg64(`KVS_REG_CYCLES_LO, 64'd0);
    axil_write(`KVS_REG_AP_CTRL, ctrl_word(1, 0, 0, 0));
    polls = 0;
    rd = '0;
    while (!rd[`KVS_BIT_DONE]) begin
      polls++;
      assert (polls <= ZERO_RUN_POLLS) else fail_now("zero-length run never reported done");
      axil_read(`KVS_REG_AP_CTRL, rd);
    end
    check_value("zero run done", ctrl_word(0, 1, 1, 1), rd);

    run_traffic("translate", REQS_PER_STREAM, 1'b0);

    // fresh bases while the streams are quiet
    ptr0_val = {$urandom, $urandom};
    ptr1_val = {$urandom, $urandom};
    write_reg64(`KVS_REG_PTR0_LO, ptr0_val);
    write_reg64(`KVS_REG_PTR1_LO, ptr1_val);
    run_traffic("backpressure", REQS_PER_STREAM, 1'b1);

    repeat (4) @(posedge ap_clk);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/kvs_bench_pkg.sv
verilog/ctrl_regs.sv
verilog/experiment_timer.sv
verilog/dram_addr_slice.sv
verilog/kvs_bench_top.sv
dv/kvs_bench_tb.sv

/* verilog/ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kvs_bench_params.svh"

module ctrl_regs (
  input  wire                              ap_clk,
  input  wire                              ap_rst_n,
  input  wire                              awvalid,
  output logic                             awready,
  input  kvs_bench_pkg::axil_addr_t        awaddr,
  input  wire                              wvalid,
  output logic                             wready,
  input  kvs_bench_pkg::axil_data_t        wdata,
  input  wire [3:0]                        wstrb,
  output logic                             bvalid,
  input  wire                              bready,
  output logic [1:0]                       bresp,
  input  wire                              arvalid,
  output logic                             arready,
  input  kvs_bench_pkg::axil_addr_t        araddr,
  output logic                             rvalid,
  input  wire                              rready,
  output kvs_bench_pkg::axil_data_t        rdata,
  output logic [1:0]                       rresp,
  output logic                             ap_start,
  output kvs_bench_pkg::kernel_cfg_t       cfg,
  input  kvs_bench_pkg::timer_status_t     status
);

  kvs_bench_pkg::wr_state_e  wr_state;
  kvs_bench_pkg::rd_state_e  rd_state;
  kvs_bench_pkg::axil_data_t rd_mux;
  logic wr_accept;
  logic ar_accept;
  logic start_req;
  logic ctrl_read;
  logic done_q; // sticky done, also reported as ready

  function automatic kvs_bench_pkg::axil_data_t apply_strb(
    input kvs_bench_pkg::axil_data_t old_v,
    input kvs_bench_pkg::axil_data_t new_v,
    input logic [3:0] strb
  );
    kvs_bench_pkg::axil_data_t res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_v[8*i +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // write side takes aw and w in the same cycle
  ////////////////////////////////////////////////////////////
  // awready holds off while only aw is pending
  assign awready = (wr_state == kvs_bench_pkg::WR_IDLE) && (wvalid || !awvalid);
  assign wready = (wr_state == kvs_bench_pkg::WR_IDLE) && awvalid && wvalid;
  assign wr_accept = awvalid && wvalid && (wr_state == kvs_bench_pkg::WR_IDLE);
  assign bvalid = (wr_state == kvs_bench_pkg::WR_RESP);
  assign bresp = 2'b00; // always OKAY

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      wr_state <= kvs_bench_pkg::WR_IDLE;
    end else if (wr_accept) begin
      wr_state <= kvs_bench_pkg::WR_RESP;
    end else if (bvalid && bready) begin
      wr_state <= kvs_bench_pkg::WR_IDLE;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cfg <= '0;
    end else if (wr_accept) begin
      case (awaddr)
        `KVS_REG_CYCLES_LO:
          cfg.time_in_cycles[31:0] <= apply_strb(cfg.time_in_cycles[31:0], wdata, wstrb);
        `KVS_REG_CYCLES_HI:
          cfg.time_in_cycles[63:32] <= apply_strb(cfg.time_in_cycles[63:32], wdata, wstrb);
        `KVS_REG_PTR0_LO: cfg.ptr0[31:0] <= apply_strb(cfg.ptr0[31:0], wdata, wstrb);
        `KVS_REG_PTR0_HI: cfg.ptr0[63:32] <= apply_strb(cfg.ptr0[63:32], wdata, wstrb);
        `KVS_REG_PTR1_LO: cfg.ptr1[31:0] <= apply_strb(cfg.ptr1[31:0], wdata, wstrb);
        `KVS_REG_PTR1_HI: cfg.ptr1[63:32] <= apply_strb(cfg.ptr1[63:32], wdata, wstrb);
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // ap_ctrl handshake bits
  ////////////////////////////////////////////////////////////
  assign start_req = wr_accept && (awaddr == `KVS_REG_AP_CTRL) && wstrb[0]
                     && wdata[`KVS_BIT_START];
  assign ctrl_read = ar_accept && (araddr == `KVS_REG_AP_CTRL);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      ap_start <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (status.done) ap_start <= 1'b0; // run finished
      else if (start_req) ap_start <= 1'b1;
      // a new done beats the clear on read
      if (status.done) done_q <= 1'b1;
      else if (ctrl_read) done_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////
  assign arready = (rd_state == kvs_bench_pkg::RD_IDLE);
  assign ar_accept = arvalid && arready;
  assign rvalid = (rd_state == kvs_bench_pkg::RD_DATA);
  assign rresp = 2'b00;

  always_comb begin
    rd_mux = '0;
    case (araddr)
      `KVS_REG_AP_CTRL: begin
        rd_mux[`KVS_BIT_START] = ap_start;
        rd_mux[`KVS_BIT_DONE] = done_q;
        rd_mux[`KVS_BIT_IDLE] = status.idle;
        rd_mux[`KVS_BIT_READY] = done_q; // ready mirrors done
      end
      `KVS_REG_CYCLES_LO: rd_mux = cfg.time_in_cycles[31:0];
      `KVS_REG_CYCLES_HI: rd_mux = cfg.time_in_cycles[63:32];
      `KVS_REG_PTR0_LO: rd_mux = cfg.ptr0[31:0];
      `KVS_REG_PTR0_HI: rd_mux = cfg.ptr0[63:32];
      `KVS_REG_PTR1_LO: rd_mux = cfg.ptr1[31:0];
      `KVS_REG_PTR1_HI: rd_mux = cfg.ptr1[63:32];
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rd_state <= kvs_bench_pkg::RD_IDLE;
    end else if (ar_accept) begin
      rd_state <= kvs_bench_pkg::RD_DATA;
    end else if (rvalid && rready) begin
      rd_state <= kvs_bench_pkg::RD_IDLE;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (ar_accept) rdata <= rd_mux;
  end

  // the timer only finishes a run that was started
  a_done_in_run: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    status.done |-> ap_start);

endmodule

`default_nettype wire

/* verilog/dram_addr_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_addr_slice (
  input  wire                            ap_clk,
  input  wire                            ap_rst_n,
  input  kvs_bench_pkg::mem_addr_t       base,
  input  wire                            in_valid,
  output logic                           in_ready,
  input  kvs_bench_pkg::local_addr_t     in_addr,
  output logic                           out_valid,
  input  wire                            out_ready,
  output kvs_bench_pkg::mem_addr_t       out_addr
);

  logic accept;
  kvs_bench_pkg::mem_addr_t global_addr;

  // local offset is unsigned, widened with zeros
  assign global_addr = base + kvs_bench_pkg::mem_addr_t'(in_addr);

  // empty stage, or the held request leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept = in_valid && in_ready;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept) out_addr <= global_addr; // base taken at accept time
  end

  // stalled request keeps its address
  a_hold_stall: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_addr));

endmodule

`default_nettype wire

/* verilog/experiment_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module experiment_timer (
  input  wire                               ap_clk,
  input  wire                               ap_rst_n,
  input  wire                               ap_start,
  input  kvs_bench_pkg::cycle_count_t       time_in_cycles,
  output kvs_bench_pkg::timer_status_t      status
);

  logic start_q;
  logic start_edge;
  logic idle_q;
  kvs_bench_pkg::cycle_count_t count_q;

  // ap_start is a level from the register file
  assign start_edge = ap_start && !start_q;

  ////////////////////////////////////////////////////////////
  // countdown
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q <= 1'b0;
      idle_q <= 1'b1;
      count_q <= '0;
    end else begin
      start_q <= ap_start;
      if (start_edge) begin
        count_q <= time_in_cycles; // load run length
        idle_q <= 1'b0;
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end else begin
        idle_q <= 1'b1;
      end
    end
  end

  // done in the last busy cycle, idle follows on the next
  always_comb begin
    status.done = !idle_q && (count_q == '0);
    status.idle = idle_q;
  end

  // a run ends once, so done is a single cycle
  a_done_pulse: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    status.done |=> !status.done);

endmodule

`default_nettype wire

/* verilog/kvs_bench_params.svh */
`ifndef KVS_BENCH_PARAMS_SVH
`define KVS_BENCH_PARAMS_SVH

// control bus
`define KVS_AXIL_ADDR_W 12
`define KVS_AXIL_DATA_W 32

// dram addressing, local offset from the movers and global bus address
`define KVS_LOCAL_ADDR_W 34
`define KVS_MEM_ADDR_W 64

// register map offsets
`define KVS_REG_AP_CTRL 12'h000
`define KVS_REG_CYCLES_LO 12'h010
`define KVS_REG_CYCLES_HI 12'h014
`define KVS_REG_PTR0_LO 12'h018
`define KVS_REG_PTR0_HI 12'h01C
`define KVS_REG_PTR1_LO 12'h020
`define KVS_REG_PTR1_HI 12'h024

// ap_ctrl bit positions
`define KVS_BIT_START 0
`define KVS_BIT_DONE 1
`define KVS_BIT_IDLE 2
`define KVS_BIT_READY 3

`endif

/* verilog/kvs_bench_pkg.sv */
`default_nettype none

`include "kvs_bench_params.svh"

package kvs_bench_pkg;

  typedef logic [`KVS_AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`KVS_AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`KVS_LOCAL_ADDR_W-1:0] local_addr_t;
  typedef logic [`KVS_MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [63:0] cycle_count_t;

  // everything the host programs before a run
  typedef struct packed {
    cycle_count_t time_in_cycles;
    mem_addr_t ptr0; // c0 base
    mem_addr_t ptr1; // c1 base
  } kernel_cfg_t;

  typedef struct packed {
    logic done; // one cycle at end of run
    logic idle;
  } timer_status_t;

  typedef enum logic [0:0] {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef enum logic [0:0] {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

endpackage

`default_nettype wire

/* verilog/kvs_bench_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kvs_bench_top (
  input  wire                              ap_clk,
  input  wire                              ap_rst_n,
  // control bus
  input  wire                              s_axi_control_awvalid,
  output logic                             s_axi_control_awready,
  input  kvs_bench_pkg::axil_addr_t        s_axi_control_awaddr,
  input  wire                              s_axi_control_wvalid,
  output logic                             s_axi_control_wready,
  input  kvs_bench_pkg::axil_data_t        s_axi_control_wdata,
  input  wire [3:0]                        s_axi_control_wstrb,
  input  wire                              s_axi_control_arvalid,
  output logic                             s_axi_control_arready,
  input  kvs_bench_pkg::axil_addr_t        s_axi_control_araddr,
  output logic                             s_axi_control_rvalid,
  input  wire                              s_axi_control_rready,
  output kvs_bench_pkg::axil_data_t        s_axi_control_rdata,
  output logic [1:0]                       s_axi_control_rresp,
  output logic                             s_axi_control_bvalid,
  input  wire                              s_axi_control_bready,
  output logic [1:0]                       s_axi_control_bresp,
  // local requests from the movers
  input  kvs_bench_pkg::local_addr_t       c0_awaddr_local,
  input  wire                              c0_awvalid_local,
  output logic                             c0_awready_local,
  input  kvs_bench_pkg::local_addr_t       c0_araddr_local,
  input  wire                              c0_arvalid_local,
  output logic                             c0_arready_local,
  input  kvs_bench_pkg::local_addr_t       c1_awaddr_local,
  input  wire                              c1_awvalid_local,
  output logic                             c1_awready_local,
  input  kvs_bench_pkg::local_addr_t       c1_araddr_local,
  input  wire                              c1_arvalid_local,
  output logic                             c1_arready_local,
  // global requests toward dram
  output kvs_bench_pkg::mem_addr_t         c0_s_axi_awaddr,
  output logic                             c0_s_axi_awvalid,
  input  wire                              c0_s_axi_awready,
  output kvs_bench_pkg::mem_addr_t         c0_s_axi_araddr,
  output logic                             c0_s_axi_arvalid,
  input  wire                              c0_s_axi_arready,
  output kvs_bench_pkg::mem_addr_t         c1_s_axi_awaddr,
  output logic                             c1_s_axi_awvalid,
  input  wire                              c1_s_axi_awready,
  output kvs_bench_pkg::mem_addr_t         c1_s_axi_araddr,
  output logic                             c1_s_axi_arvalid,
  input  wire                              c1_s_axi_arready
);

  logic ap_start;
  kvs_bench_pkg::kernel_cfg_t   cfg;
  kvs_bench_pkg::timer_status_t status;

  ctrl_regs ctrl_regs_inst (
    .ap_clk   (ap_clk),                .ap_rst_n (ap_rst_n),
    .awvalid  (s_axi_control_awvalid), .awready  (s_axi_control_awready),
    .awaddr   (s_axi_control_awaddr),
    .wvalid   (s_axi_control_wvalid),  .wready   (s_axi_control_wready),
    .wdata    (s_axi_control_wdata),   .wstrb    (s_axi_control_wstrb),
    .bvalid   (s_axi_control_bvalid),  .bready   (s_axi_control_bready),
    .bresp    (s_axi_control_bresp),
    .arvalid  (s_axi_control_arvalid), .arready  (s_axi_control_arready),
    .araddr   (s_axi_control_araddr),
    .rvalid   (s_axi_control_rvalid),  .rready   (s_axi_control_rready),
    .rdata    (s_axi_control_rdata),   .rresp    (s_axi_control_rresp),
    .ap_start (ap_start),
    .cfg      (cfg),
    .status   (status)
  );

  experiment_timer experiment_timer_inst (
    .ap_clk         (ap_clk),
    .ap_rst_n       (ap_rst_n),
    .ap_start       (ap_start),
    .time_in_cycles (cfg.time_in_cycles),
    .status         (status)
  );

  ////////////////////////////////////////////////////////////
  // address translation, ptr0 for c0 and ptr1 for c1
  ////////////////////////////////////////////////////////////
  dram_addr_slice c0_aw_slice (
    .ap_clk   (ap_clk),           .ap_rst_n  (ap_rst_n),     .base     (cfg.ptr0),
    .in_valid (c0_awvalid_local), .in_ready  (c0_awready_local),
    .in_addr  (c0_awaddr_local),  .out_valid (c0_s_axi_awvalid),
    .out_ready(c0_s_axi_awready), .out_addr  (c0_s_axi_awaddr)
  );

  dram_addr_slice c0_ar_slice (
    .ap_clk   (ap_clk),           .ap_rst_n  (ap_rst_n),     .base     (cfg.ptr0),
    .in_valid (c0_arvalid_local), .in_ready  (c0_arready_local),
    .in_addr  (c0_araddr_local),  .out_valid (c0_s_axi_arvalid),
    .out_ready(c0_s_axi_arready), .out_addr  (c0_s_axi_araddr)
  );

  dram_addr_slice c1_aw_slice (
    .ap_clk   (ap_clk),           .ap_rst_n  (ap_rst_n),     .base     (cfg.ptr1),
    .in_valid (c1_awvalid_local), .in_ready  (c1_awready_local),
    .in_addr  (c1_awaddr_local),  .out_valid (c1_s_axi_awvalid),
    .out_ready(c1_s_axi_awready), .out_addr  (c1_s_axi_awaddr)
  );

  dram_addr_slice c1_ar_slice (
    .ap_clk   (ap_clk),           .ap_rst_n  (ap_rst_n),     .base     (cfg.ptr1),
    .in_valid (c1_arvalid_local), .in_ready  (c1_arready_local),
    .in_addr  (c1_araddr_local),  .out_valid (c1_s_axi_arvalid),
    .out_ready(c1_s_axi_arready), .out_addr  (c1_s_axi_araddr)
  );

endmodule

`default_nettype wire
